// File: hw/nn_settings.svh
`ifndef NN_SETTINGS_SVH
`define NN_SETTINGS_SVH

// layer dimensions
`define NN_INPUTS 8
`define NN_NEURONS 4

// output stage, sum is Q.6 before quantization
`define NN_FRAC_SHIFT 6
`define NN_SAT_MAX 127
`define NN_ACC_BITS 23

`endif

// File: hw/nnDataPkg.sv
`include "nn_settings.svh"

package nnDataPkg;

	typedef logic signed [7:0] activation_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] bias_t;
	typedef logic signed [15:0] product_t; // full 8x8 product
	typedef logic signed [`NN_ACC_BITS-1:0] acc_t;

	// one input sample, element 0 in the low byte
	typedef struct packed {
		activation_t [`NN_INPUTS-1:0] act;
	} inputVec_t;

	typedef struct packed {
		activation_t [`NN_NEURONS-1:0] act;
	} layerOut_t;

endpackage

// File: hw/nnCtrlPkg.sv
package nnCtrlPkg;

	typedef enum logic [2:0] {
		idle,
		load,
		mac,
		bias,
		activate,
		finish
	} seqState_t;

	typedef enum logic [1:0] {
		accHold,
		accClear,
		accMac,
		accBias
	} accOp_t;

endpackage

// File: hw/indexCounter.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module indexCounter (
	input logic clk,
	input logic reset,
	input logic clearIdx,
	input logic stepInput,
	input logic stepNeuron,
	output logic [$clog2(`NN_INPUTS)-1:0] inIdx,
	output logic [$clog2(`NN_NEURONS)-1:0] neuronIdx,
	output logic lastInput,
	output logic lastNeuron
);
	localparam int InBits = $clog2(`NN_INPUTS);
	localparam int NeuronBits = $clog2(`NN_NEURONS);

	assign lastInput = (inIdx == InBits'(`NN_INPUTS - 1));
	assign lastNeuron = (neuronIdx == NeuronBits'(`NN_NEURONS - 1));

	always_ff @(posedge clk)
	begin
		if (reset || clearIdx)
			inIdx <= '0;
		else if (stepInput)
		begin
			if (lastInput)
				inIdx <= '0; // wrap for next neuron
			else
				inIdx <= inIdx + InBits'(1);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset || clearIdx)
			neuronIdx <= '0;
		else if (stepNeuron)
		begin
			if (lastNeuron)
				neuronIdx <= '0;
			else
				neuronIdx <= neuronIdx + NeuronBits'(1);
		end
	end

endmodule

// File: hw/layerSequencer.sv
`timescale 1ns/1ps

module layerSequencer (
	input logic clk,
	input logic reset,
	input logic start,
	input logic lastInput,
	input logic lastNeuron,
	output logic capture,
	output nnCtrlPkg::accOp_t accOp,
	output logic clearIdx,
	output logic stepInput,
	output logic stepNeuron,
	output logic writeOut,
	output logic busy,
	output logic done
);
	import nnCtrlPkg::*;

	seqState_t state;
	seqState_t nextState;

	always_comb
	begin
		nextState = state;
		case (state)
			idle:
				if (start)
					nextState = load; // start while busy never reaches here
			load:
				nextState = mac;
			mac:
				if (lastInput)
					nextState = bias;
			bias:
				nextState = activate;
			activate:
				nextState = lastNeuron ? finish : mac;
			finish:
				nextState = idle;
			default:
				nextState = idle;
		endcase
	end

	assign capture = (state == idle) && start; // inVec valid only with start
	assign clearIdx = (state == load);
	assign stepInput = (state == mac);
	assign stepNeuron = (state == activate);
	assign writeOut = (state == activate); // acc holds sum plus bias here

	always_comb
	begin
		case (state)
			load, activate:
				accOp = accClear;
			mac:
				accOp = accMac;
			bias:
				accOp = accBias;
			default:
				accOp = accHold;
		endcase
	end

	// done one edge after finish so the last result is already stored
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			state <= nextState;
			busy <= (nextState != idle);
			done <= (state == finish);
		end
	end

endmodule

// File: hw/weightRom.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module weightRom (
	input logic [$clog2(`NN_INPUTS)-1:0] inIdx,
	input logic [$clog2(`NN_NEURONS)-1:0] neuronIdx,
	output nnDataPkg::weight_t weight,
	output nnDataPkg::bias_t bias
);
	logic [$clog2(`NN_NEURONS)+$clog2(`NN_INPUTS)-1:0] romAddr;

	assign romAddr = {neuronIdx, inIdx};

	// w = (37 * addr) mod 31 - 15
	always_comb
	begin
		case (romAddr)
			5'd0: weight = -8'sd15;
			5'd1: weight = -8'sd9;
			5'd2: weight = -8'sd3;
			5'd3: weight = 8'sd3;
			5'd4: weight = 8'sd9;
			5'd5: weight = 8'sd15;
			5'd6: weight = -8'sd10;
			5'd7: weight = -8'sd4;
			5'd8: weight = 8'sd2;
			5'd9: weight = 8'sd8;
			5'd10: weight = 8'sd14;
			5'd11: weight = -8'sd11;
			5'd12: weight = -8'sd5;
			5'd13: weight = 8'sd1;
			5'd14: weight = 8'sd7;
			5'd15: weight = 8'sd13;
			5'd16: weight = -8'sd12;
			5'd17: weight = -8'sd6;
			5'd18: weight = 8'sd0;
			5'd19: weight = 8'sd6;
			5'd20: weight = 8'sd12;
			5'd21: weight = -8'sd13;
			5'd22: weight = -8'sd7;
			5'd23: weight = -8'sd1;
			5'd24: weight = 8'sd5;
			5'd25: weight = 8'sd11;
			5'd26: weight = -8'sd14;
			5'd27: weight = -8'sd8;
			5'd28: weight = -8'sd2;
			5'd29: weight = 8'sd4;
			5'd30: weight = 8'sd10;
			default: weight = -8'sd15; // addr 31
		endcase
	end

	always_comb
	begin
		case (neuronIdx)
			2'd0: bias = 16'sd512;
			2'd1: bias = 16'sd256;
			2'd2: bias = 16'sd0;
			default: bias = -16'sd256;
		endcase
	end

endmodule

// File: hw/macUnit.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module macUnit (
	input logic clk,
	input logic reset,
	input logic capture,
	input nnDataPkg::inputVec_t inVec,
	input logic [$clog2(`NN_INPUTS)-1:0] inIdx,
	input nnDataPkg::weight_t weight,
	input nnDataPkg::bias_t bias,
	input nnCtrlPkg::accOp_t accOp,
	output nnDataPkg::acc_t acc
);
	import nnDataPkg::*;
	import nnCtrlPkg::*;

	localparam int ProdBits = $bits(product_t);
	localparam int BiasBits = $bits(bias_t);

	inputVec_t inReg;
	activation_t curAct;
	product_t product;
	acc_t productExt;
	acc_t biasExt;

	always_ff @(posedge clk)
	begin
		if (capture)
			inReg <= inVec; // held for the whole layer
	end

	assign curAct = inReg.act[inIdx];
	assign product = curAct * weight;
	assign productExt = {{(`NN_ACC_BITS - ProdBits){product[ProdBits-1]}}, product};
	assign biasExt = {{(`NN_ACC_BITS - BiasBits){bias[BiasBits-1]}}, bias};

	always_ff @(posedge clk)
	begin
		if (reset)
			acc <= '0;
		else
		begin
			case (accOp)
				accClear:
					acc <= '0;
				accMac:
					acc <= acc + productExt;
				accBias:
					acc <= acc + biasExt;
				default:
					acc <= acc;
			endcase
		end
	end

endmodule

// File: hw/reluQuantizer.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module reluQuantizer (
	input logic clk,
	input logic reset,
	input nnDataPkg::acc_t acc,
	input logic writeOut,
	input logic [$clog2(`NN_NEURONS)-1:0] neuronIdx,
	output nnDataPkg::layerOut_t result
);
	import nnDataPkg::*;

	localparam acc_t RoundBit = acc_t'(1) << (`NN_FRAC_SHIFT - 1);
	localparam acc_t SatMax = acc_t'(`NN_SAT_MAX);

	acc_t rounded;
	activation_t qValue;

	// half up on the first dropped bit
	assign rounded = (acc + RoundBit) >>> `NN_FRAC_SHIFT;

	always_comb
	begin
		if (acc[`NN_ACC_BITS-1])
			qValue = '0; // relu
		else if (rounded > SatMax)
			qValue = activation_t'(`NN_SAT_MAX);
		else
			qValue = activation_t'(rounded);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else if (writeOut)
			result.act[neuronIdx] <= qValue;
	end

endmodule

// File: hw/denseLayer.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module denseLayer (
	input logic clk,
	input logic reset,
	input logic start,
	input nnDataPkg::inputVec_t inVec,
	output logic busy,
	output logic done,
	output nnDataPkg::layerOut_t result
);
	import nnDataPkg::*;
	import nnCtrlPkg::*;

	logic capture;
	logic clearIdx;
	logic stepInput;
	logic stepNeuron;
	logic writeOut;
	logic lastInput;
	logic lastNeuron;
	logic [$clog2(`NN_INPUTS)-1:0] inIdx;
	logic [$clog2(`NN_NEURONS)-1:0] neuronIdx;
	accOp_t accOp;
	weight_t romWeight;
	bias_t romBias;
	acc_t accValue;

	layerSequencer i_layerSequencer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.lastInput(lastInput),
		.lastNeuron(lastNeuron),
		.capture(capture),
		.accOp(accOp),
		.clearIdx(clearIdx),
		.stepInput(stepInput),
		.stepNeuron(stepNeuron),
		.writeOut(writeOut),
		.busy(busy),
		.done(done)
	);

	indexCounter i_indexCounter (
		.clk(clk),
		.reset(reset),
		.clearIdx(clearIdx),
		.stepInput(stepInput),
		.stepNeuron(stepNeuron),
		.inIdx(inIdx),
		.neuronIdx(neuronIdx),
		.lastInput(lastInput),
		.lastNeuron(lastNeuron)
	);

	weightRom i_weightRom (
		.inIdx(inIdx),
		.neuronIdx(neuronIdx),
		.weight(romWeight),
		.bias(romBias)
	);

	macUnit i_macUnit (
		.clk(clk),
		.reset(reset),
		.capture(capture),
		.inVec(inVec),
		.inIdx(inIdx),
		.weight(romWeight),
		.bias(romBias),
		.accOp(accOp),
		.acc(accValue)
	);

	reluQuantizer i_reluQuantizer (
		.clk(clk),
		.reset(reset),
		.acc(accValue),
		.writeOut(writeOut),
		.neuronIdx(neuronIdx),
		.result(result)
	);

endmodule

// File: tb/denseLayer_sva.sv
`timescale 1ns/1ps

module denseLayer_sva (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done
);

	doneOneCycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
	else
		$error("done stayed high for more than one cycle");

	busyNotWithDone: assert property (@(posedge clk) disable iff (reset) !(busy && done))
	else
		$error("busy and done high in the same cycle");

	// done is registered, so it is low from the edge after reset is seen
	doneLowInReset: assert property (@(posedge clk) reset |=> !done)
	else
		$error("done high while reset is asserted");

endmodule

bind denseLayer denseLayer_sva i_denseLayer_sva (
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.done(done)
);

// File: tb/denseLayer_tb.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module denseLayer_tb;
	import nnDataPkg::*;

	localparam int NumFixed = 6;
	localparam int NumRandom = 5;
	localparam int NumRows = NumFixed + NumRandom;
	localparam int ResetCycles = 10;
	localparam int Latency = 1 + `NN_NEURONS * (`NN_INPUTS + 2) + 1;
	localparam int TimeoutCycles = (NumRows + 2) * 50 + ResetCycles;
	localparam int QuietCycles = 45; // longer than a full computation

	logic clk;
	logic reset;
	logic start;
	inputVec_t inVec;
	logic busy;
	logic done;
	layerOut_t result;

	inputVec_t stimTable [NumRows];
	layerOut_t expTable [NumRows];
	integer seed;
	int cycleCount = 0;

	denseLayer i_denseLayer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.inVec(inVec),
		.busy(busy),
		.done(done),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	task automatic stopRun(string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		assert (cycleCount < TimeoutCycles)
		else
			stopRun($sformatf("timeout, run still going after %0d cycles", cycleCount));
	end

	// w(n, i) = (37 * (8n + i)) mod 31 - 15
	function automatic int weightOf(int n, int i);
		return ((37 * (8 * n + i)) % 31) - 15;
	endfunction

	function automatic int biasOf(int n);
		return 512 - 256 * n;
	endfunction

	function automatic int quantize(int sum);
		int q;
		if (sum < 0)
			return 0; // relu
		q = (sum + (1 << (`NN_FRAC_SHIFT - 1))) / (1 << `NN_FRAC_SHIFT);
		return (q > `NN_SAT_MAX) ? `NN_SAT_MAX : q;
	endfunction

	function automatic layerOut_t expectedOutputs(inputVec_t v);
		layerOut_t r;
		int sum;
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			sum = biasOf(n);
			for (int i = 0; i < `NN_INPUTS; i++)
				sum += weightOf(n, i) * int'(v.act[i]);
			r.act[n] = activation_t'(quantize(sum));
		end
		return r;
	endfunction

	task automatic fillTable();
		for (int r = 0; r < NumRows; r++)
			stimTable[r] = '0;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			stimTable[1].act[i] = activation_t'(127); // saturation row
			stimTable[2].act[i] = activation_t'(-128); // negative row
			// signs follow the neuron 0 weights so its sum clamps
			stimTable[5].act[i] = (weightOf(0, i) < 0) ? activation_t'(-128)
				: activation_t'(127);
		end
		stimTable[3].act[0] = activation_t'(16); // exact half on neuron 1
		stimTable[4].act[0] = activation_t'(15); // just below half
		for (int r = NumFixed; r < NumRows; r++)
			for (int i = 0; i < `NN_INPUTS; i++)
				stimTable[r].act[i] = activation_t'($random(seed));
		for (int r = 0; r < NumRows; r++)
			expTable[r] = expectedOutputs(stimTable[r]);
	endtask

	task automatic checkOutputs(int row);
		for (int n = 0; n < `NN_NEURONS; n++)
			assert (result.act[n] == expTable[row].act[n])
			else
				stopRun($sformatf("mismatch at %0t: row %0d neuron %0d got %0d expected %0d",
					$time, row, n, result.act[n], expTable[row].act[n]));
	endtask

	// ignoredRow >= 0 sends a second start with that vector while busy
	task automatic applyRow(int row, int ignoredRow);
		int waited;
		int quiet;
		quiet = (ignoredRow >= 0) ? QuietCycles : 1;
		@(negedge clk);
		start = 1'b1;
		inVec = stimTable[row];
		@(negedge clk);
		start = 1'b0;
		inVec = ~stimTable[row]; // no longer sampled once start is low
		waited = 0;
		while (!done)
		begin
			assert (busy)
			else
				stopRun($sformatf("busy low %0d cycles after start and no done yet", waited));
			@(negedge clk);
			waited++;
			start = (ignoredRow >= 0) && (waited == 5);
			if (start)
				inVec = stimTable[ignoredRow];
		end
		assert (waited == Latency)
		else
			stopRun($sformatf("mismatch at %0t: done after %0d cycles, expected %0d",
				$time, waited, Latency));
		assert (!busy)
		else
			stopRun("busy still high in the cycle done is high");
		checkOutputs(row);
		repeat (quiet)
		begin
			@(negedge clk);
			assert (!done && !busy)
			else
				stopRun("done or busy high again after the computation ended");
			checkOutputs(row); // result holds
		end
	endtask

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		inVec = '0;
		seed = 32'hfb6cf7bc;
		fillTable();
		assert (expTable[0] == {8'd0, 8'd0, 8'd4, 8'd8})
		else
			stopRun("reference model gives wrong outputs for the all-zero vector");
		repeat (ResetCycles) @(negedge clk);
		reset = 1'b0;
		assert (!busy && !done)
		else
			stopRun("busy or done high right after reset");
		assert (result == '0)
		else
			stopRun($sformatf("mismatch at %0t: result %h after reset", $time, result));
		for (int r = 0; r < NumRows; r++)
			applyRow(r, -1);
		applyRow(3, 1);
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+hw
hw/nnDataPkg.sv
hw/nnCtrlPkg.sv
hw/indexCounter.sv
hw/layerSequencer.sv
hw/weightRom.sv
hw/macUnit.sv
hw/reluQuantizer.sv
hw/denseLayer.sv
tb/denseLayer_sva.sv
tb/denseLayer_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the dense layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module denseLayer_tb -o simDenseLayer
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

simOutput=$(./obj_dir/simDenseLayer)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOutput" | grep -qx "Simulation passed"; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1
